//--- sources.f
+incdir+src
src/l2_cache_pkg.sv
src/rr_arbiter.sv
src/l2_cache_arb.sv
src/l2_cache_tag.sv
src/l2_cache_data.sv
src/l2_bus_interface.sv
src/l2_cache_top.sv
verif/tb_clock_gen.sv
verif/l2_cache_tb.sv

//--- src/l2_bus_interface.sv
// L2 bus interface, queues misses and stores in order and sequences them on the memory port
`timescale 1ns/100ps
`include "l2_cache_settings.svh"

module l2_bus_interface
	import l2_cache_pkg::*;
(
	input clk,
	input reset,

	// From the data stage
	input miss_push,
	input miss_store,
	input core_id_t miss_core,
	input l2_addr_t miss_addr,
	input cache_line_t miss_data,

	// Restarts and flow control to the arbitration stage
	output logic bi_restart,
	output core_id_t bi_restart_core,
	output l2_addr_t bi_restart_addr,
	output cache_line_t bi_fill_data,
	output logic bi_collided,
	output logic bi_stall,

	// External memory port
	output logic mem_read_req,
	output logic mem_write_req,
	output l2_addr_t mem_addr,
	output cache_line_t mem_write_data,
	input mem_read_valid,
	input cache_line_t mem_read_data
);

	localparam ptr_bits = $clog2(`L2_MISS_QUEUE_DEPTH);

	// Miss queue storage, one entry per store or missed load
	logic fifo_store[`L2_MISS_QUEUE_DEPTH];
	core_id_t fifo_core[`L2_MISS_QUEUE_DEPTH];
	l2_addr_t fifo_addr[`L2_MISS_QUEUE_DEPTH];
	cache_line_t fifo_data[`L2_MISS_QUEUE_DEPTH];

	logic [ptr_bits - 1:0] rd_ptr;
	logic [ptr_bits - 1:0] wr_ptr;
	miss_count_t miss_count;
	bus_state_t state;

	// Most recently filled line, still resident because nothing else has filled since
	l2_addr_t last_fill_addr;
	logic last_fill_valid;
	cache_line_t fill_data;

	logic head_ready;
	logic head_collided;
	logic pop;

	// Head entry can be acted on only when the sequencer is free
	assign head_ready = state == bus_idle && miss_count != '0;
	assign head_collided = last_fill_valid && fifo_addr[rd_ptr] == last_fill_addr;

	assign mem_addr = fifo_addr[rd_ptr];
	assign mem_write_data = fifo_data[rd_ptr];
	assign mem_write_req = head_ready && fifo_store[rd_ptr];
	assign mem_read_req = head_ready && !fifo_store[rd_ptr] && !head_collided;

	// A load that missed on the line just filled is sent back without a memory read
	assign bi_collided = head_ready && !fifo_store[rd_ptr] && head_collided;
	assign bi_restart = bi_collided || state == bus_restart;
	assign bi_restart_core = fifo_core[rd_ptr];
	assign bi_restart_addr = fifo_addr[rd_ptr];
	assign bi_fill_data = fill_data;

	// Three spare entries absorb whatever is still in the arb, tag and data stages
	assign bi_stall = miss_count >= miss_count_t'(`L2_MISS_QUEUE_DEPTH - 3);

	// Stores leave as soon as memory takes them, loads once they are restarted
	assign pop = mem_write_req || bi_restart;

	always_ff @(posedge clk)
	begin
		if (miss_push)
		begin
			fifo_store[wr_ptr] <= miss_store;
			fifo_core[wr_ptr] <= miss_core;
			fifo_addr[wr_ptr] <= miss_addr;
			fifo_data[wr_ptr] <= miss_data;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			miss_count <= '0;
		end
		else
		begin
			if (miss_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (miss_push && !pop)
				miss_count <= miss_count + 1'b1;
			else if (pop && !miss_push)
				miss_count <= miss_count - 1'b1;
		end
	end

	// Only one read is ever outstanding, so the sequencer waits in read_wait
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= bus_idle;
			last_fill_valid <= 1'b0;
		end
		else
		begin
			unique case (state)
				bus_idle:
				begin
					if (mem_read_req)
						state <= bus_read_wait;
				end

				bus_read_wait:
				begin
					if (mem_read_valid)
						state <= bus_restart;
				end

				bus_restart:
				begin
					state <= bus_idle;
					last_fill_valid <= 1'b1;
				end

				default:
					state <= bus_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == bus_read_wait && mem_read_valid)
			fill_data <= mem_read_data;
		if (state == bus_restart)
			last_fill_addr <= fifo_addr[rd_ptr];
	end
endmodule

//--- src/l2_cache_arb.sv
// First L2 pipeline stage, chooses between a restart from the bus interface and a core request
`timescale 1ns/100ps
`include "l2_cache_settings.svh"

module l2_cache_arb
	import l2_cache_pkg::*;
(
	input clk,
	input reset,

	// Requests from the cores
	input logic core_req_valid[`L2_NUM_CORES],
	input logic core_req_store[`L2_NUM_CORES],
	input l2_addr_t core_req_addr[`L2_NUM_CORES],
	input cache_line_t core_req_data[`L2_NUM_CORES],
	output logic l2_ready[`L2_NUM_CORES],

	// Restarted requests and flow control from the bus interface
	input bi_restart,
	input core_id_t bi_restart_core,
	input l2_addr_t bi_restart_addr,
	input cache_line_t bi_fill_data,
	input bi_collided,
	input bi_stall,

	// To the tag stage
	output logic arb_valid,
	output core_id_t arb_core,
	output logic arb_store,
	output l2_addr_t arb_addr,
	output cache_line_t arb_data,
	output logic arb_is_fill,
	output cache_line_t arb_fill_data
);

	logic [`L2_NUM_CORES - 1:0] core_request;
	logic [`L2_NUM_CORES - 1:0] grant_oh;
	core_id_t grant_idx;
	logic can_accept;
	logic accept_core;

	// A restart owns the stage outright, and a stall keeps the miss queue from overflowing
	assign can_accept = !bi_restart && !bi_stall;
	assign accept_core = |grant_oh && can_accept;

	// Ready follows valid combinationally, so a core must not wait for ready to raise valid
	always_comb
	begin
		for (int i = 0; i < `L2_NUM_CORES; i++)
		begin
			core_request[i] = core_req_valid[i];
			l2_ready[i] = grant_oh[i] && can_accept;
		end
	end

	// Turn the one-hot grant into an index for the payload mux
	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < `L2_NUM_CORES; i++)
		begin
			if (grant_oh[i])
				grant_idx = core_id_t'(i);
		end
	end

	// Priority moves only when the granted request really enters the pipeline
	rr_arbiter #(.num_entries(`L2_NUM_CORES)) u_rr_arbiter(
		.clk(clk),
		.reset(reset),
		.request(core_request),
		.update(can_accept),
		.grant_oh(grant_oh));

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			arb_valid <= 1'b0;
			arb_is_fill <= 1'b0;
		end
		else if (bi_restart)
		begin
			// A collided miss carries no line and just has to hit in the tag stage
			arb_valid <= 1'b1;
			arb_is_fill <= !bi_collided;
		end
		else
		begin
			arb_valid <= accept_core;
			arb_is_fill <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (bi_restart)
		begin
			// Only loads are ever restarted
			arb_core <= bi_restart_core;
			arb_store <= 1'b0;
			arb_addr <= bi_restart_addr;
			arb_fill_data <= bi_fill_data;
		end
		else if (accept_core)
		begin
			arb_core <= grant_idx;
			arb_store <= core_req_store[grant_idx];
			arb_addr <= core_req_addr[grant_idx];
			arb_data <= core_req_data[grant_idx];
		end
	end
endmodule

//--- src/l2_cache_data.sv
// Last L2 pipeline stage, reads and writes the line array, answers cores and queues misses
`timescale 1ns/100ps
`include "l2_cache_settings.svh"

module l2_cache_data
	import l2_cache_pkg::*;
(
	input clk,
	input reset,

	// From the tag stage
	input tag_valid,
	input core_id_t tag_core,
	input tag_store,
	input l2_addr_t tag_addr,
	input cache_line_t tag_data,
	input tag_is_fill,
	input cache_line_t tag_fill_data,
	input tag_hit,

	// Responses to the cores, one cycle each
	output logic resp_valid,
	output core_id_t resp_core,
	output logic resp_store,
	output l2_addr_t resp_addr,
	output cache_line_t resp_data,

	// To the bus interface miss queue
	output logic miss_push,
	output logic miss_store,
	output core_id_t miss_core,
	output l2_addr_t miss_addr,
	output cache_line_t miss_data
);

	localparam set_bits = $bits(l2_set_idx_t);

	cache_line_t line_array[`L2_NUM_SETS];

	l2_set_idx_t line_set;
	logic line_write;
	cache_line_t write_data;

	assign line_set = tag_addr[set_bits - 1:0];

	// Fills install their line and store hits overwrite it
	// A store miss leaves the array alone since there is no allocation
	assign line_write = tag_valid && (tag_is_fill || (tag_store && tag_hit));
	assign write_data = tag_is_fill ? tag_fill_data : tag_data;

	always_ff @(posedge clk)
	begin
		if (line_write)
			line_array[line_set] <= write_data;
	end

	// Stores answer at once whether or not they hit
	// Loads answer only on a hit, which includes fills and collided restarts
	// Every store goes to memory, a load only when it missed
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			resp_valid <= 1'b0;
			miss_push <= 1'b0;
		end
		else
		begin
			resp_valid <= tag_valid && (tag_hit || tag_store);
			miss_push <= tag_valid && (tag_store || !tag_hit);
		end
	end

	always_ff @(posedge clk)
	begin
		resp_core <= tag_core;
		resp_store <= tag_store;
		resp_addr <= tag_addr;

		// Fills and stores return the line they carry, load hits return the array contents
		if (tag_is_fill || tag_store)
			resp_data <= write_data;
		else
			resp_data <= line_array[line_set];

		miss_store <= tag_store;
		miss_core <= tag_core;
		miss_addr <= tag_addr;
		miss_data <= tag_data;
	end
endmodule

//--- src/l2_cache_pkg.sv
// Types shared by the L2 cache pipeline and its testbench, pulled in by a wildcard import
`include "l2_cache_settings.svh"

package l2_cache_pkg;
	// Index of a requesting core, kept one bit wide even for a single core
	typedef logic [(`L2_NUM_CORES > 1 ? $clog2(`L2_NUM_CORES) : 1) - 1:0] core_id_t;

	// Address of a whole cache line
	typedef logic [`L2_ADDR_BITS - 1:0] l2_addr_t;

	// Payload of one cache line
	typedef logic [`L2_LINE_BITS - 1:0] cache_line_t;

	// The set index is taken from the low bits of the line address
	typedef logic [$clog2(`L2_NUM_SETS) - 1:0] l2_set_idx_t;

	// The tag holds whatever address bits the set index leaves over
	typedef logic [`L2_ADDR_BITS - $clog2(`L2_NUM_SETS) - 1:0] l2_tag_t;

	// Miss queue occupancy, wide enough to count a completely full queue
	typedef logic [$clog2(`L2_MISS_QUEUE_DEPTH + 1) - 1:0] miss_count_t;

	// States of the memory sequencer in the bus interface
	// Idle picks up the head of the miss queue, read_wait holds until memory answers,
	// restart sends the returned line back into the pipeline as a fill
	typedef enum logic [1:0]
	{
		bus_idle,
		bus_read_wait,
		bus_restart
	} bus_state_t;
endpackage

//--- src/l2_cache_settings.svh
// Size constants for the shared L2 cache, included by the package, every RTL file and the testbench
`ifndef L2_CACHE_SETTINGS_SVH
`define L2_CACHE_SETTINGS_SVH

// Number of cores that can send requests to the L2
`define L2_NUM_CORES 4

// Width of one cache line in bits, which is also the unit of every transfer
`define L2_LINE_BITS 128

// Width of a line address, so byte offsets within a line are not carried at all
`define L2_ADDR_BITS 26

// Sets in the direct-mapped tag and line arrays
`define L2_NUM_SETS 16

// Entries in the bus interface miss queue, a power of two
`define L2_MISS_QUEUE_DEPTH 8

`endif

//--- src/l2_cache_tag.sv
// Second L2 pipeline stage, looks up the direct-mapped tag array and installs tags for fills
`timescale 1ns/100ps
`include "l2_cache_settings.svh"

module l2_cache_tag
	import l2_cache_pkg::*;
(
	input clk,
	input reset,

	// From the arbitration stage
	input arb_valid,
	input core_id_t arb_core,
	input arb_store,
	input l2_addr_t arb_addr,
	input cache_line_t arb_data,
	input arb_is_fill,
	input cache_line_t arb_fill_data,

	// To the data stage
	output logic tag_valid,
	output core_id_t tag_core,
	output logic tag_store,
	output l2_addr_t tag_addr,
	output cache_line_t tag_data,
	output logic tag_is_fill,
	output cache_line_t tag_fill_data,
	output logic tag_hit
);

	localparam set_bits = $bits(l2_set_idx_t);

	// One tag and one valid bit per set
	l2_tag_t tag_array[`L2_NUM_SETS];
	logic [`L2_NUM_SETS - 1:0] line_valid;

	l2_set_idx_t lookup_set;
	l2_tag_t lookup_tag;
	logic lookup_hit;
	logic install;

	// Split the line address into set index and tag
	assign lookup_set = arb_addr[set_bits - 1:0];
	assign lookup_tag = arb_addr[`L2_ADDR_BITS - 1:set_bits];

	assign lookup_hit = line_valid[lookup_set] && tag_array[lookup_set] == lookup_tag;

	// A fill replaces whatever line lived in its set
	assign install = arb_valid && arb_is_fill;

	// Tag is written at the same edge that moves the fill on
	// so the request right behind it already sees the new line
	always_ff @(posedge clk)
	begin
		if (install)
			tag_array[lookup_set] <= lookup_tag;
	end

	// All lines start out invalid
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			line_valid <= '0;
		else if (install)
			line_valid[lookup_set] <= 1'b1;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			tag_valid <= 1'b0;
			tag_is_fill <= 1'b0;
		end
		else
		begin
			tag_valid <= arb_valid;
			tag_is_fill <= arb_is_fill;
		end
	end

	// A fill always counts as a hit since it brings its own line
	always_ff @(posedge clk)
	begin
		tag_core <= arb_core;
		tag_store <= arb_store;
		tag_addr <= arb_addr;
		tag_data <= arb_data;
		tag_fill_data <= arb_fill_data;
		tag_hit <= arb_is_fill || lookup_hit;
	end
endmodule

//--- src/l2_cache_top.sv
// Top of the shared L2 cache, ties the three pipeline stages to the bus interface
`timescale 1ns/100ps
`include "l2_cache_settings.svh"

module l2_cache_top
	import l2_cache_pkg::*;
(
	input clk,
	input reset,

	// Core request ports
	input logic core_req_valid[`L2_NUM_CORES],
	input logic core_req_store[`L2_NUM_CORES],
	input l2_addr_t core_req_addr[`L2_NUM_CORES],
	input cache_line_t core_req_data[`L2_NUM_CORES],
	output logic l2_ready[`L2_NUM_CORES],

	// Responses, shared by all cores and tagged with the core index
	output logic resp_valid,
	output core_id_t resp_core,
	output logic resp_store,
	output l2_addr_t resp_addr,
	output cache_line_t resp_data,

	// External memory
	output logic mem_read_req,
	output logic mem_write_req,
	output l2_addr_t mem_addr,
	output cache_line_t mem_write_data,
	input mem_read_valid,
	input cache_line_t mem_read_data
);

	// Arbitration stage to tag stage
	logic arb_valid;
	core_id_t arb_core;
	logic arb_store;
	l2_addr_t arb_addr;
	cache_line_t arb_data;
	logic arb_is_fill;
	cache_line_t arb_fill_data;

	// Tag stage to data stage
	logic tag_valid;
	core_id_t tag_core;
	logic tag_store;
	l2_addr_t tag_addr;
	cache_line_t tag_data;
	logic tag_is_fill;
	cache_line_t tag_fill_data;
	logic tag_hit;

	// Data stage to miss queue
	logic miss_push;
	logic miss_store;
	core_id_t miss_core;
	l2_addr_t miss_addr;
	cache_line_t miss_data;

	// Bus interface back to arbitration
	logic bi_restart;
	core_id_t bi_restart_core;
	l2_addr_t bi_restart_addr;
	cache_line_t bi_fill_data;
	logic bi_collided;
	logic bi_stall;

	// Stages run in pipeline order and the bus interface closes the loop back to arbitration
	l2_cache_arb u_l2_cache_arb(.*);
	l2_cache_tag u_l2_cache_tag(.*);
	l2_cache_data u_l2_cache_data(.*);
	l2_bus_interface u_l2_bus_interface(.*);
endmodule

//--- src/rr_arbiter.sv
// Round-robin arbiter with a one-hot grant, used by the arbitration stage to pick a core
`timescale 1ns/100ps

module rr_arbiter
	#(parameter num_entries = 4)
(
	input clk,
	input reset,
	input [num_entries - 1:0] request,
	input update,
	output logic [num_entries - 1:0] grant_oh
);

	localparam idx_bits = num_entries > 1 ? $clog2(num_entries) : 1;

	// Entry that has the highest priority in the current cycle
	logic [idx_bits - 1:0] priority_ptr;

	// Binary index of the winner, used to move the pointer
	logic [idx_bits - 1:0] grant_idx;

	// Scan upward from the priority entry with wrap-around and stop at the first requester
	// The grant is purely combinational so a core sees ready in the same cycle
	always_comb
	begin
		logic found;
		int slot;

		found = 1'b0;
		slot = 0;
		grant_oh = '0;
		grant_idx = '0;
		for (int offset = 0; offset < num_entries; offset++)
		begin
			slot = (int'(priority_ptr) + offset) % num_entries;
			if (!found && request[slot])
			begin
				found = 1'b1;
				grant_oh[slot] = 1'b1;
				grant_idx = idx_bits'(slot);
			end
		end
	end

	// The pointer only advances when the grant was actually used
	// The entry after the winner becomes the new top priority
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			priority_ptr <= '0;
		else if (update && |grant_oh)
		begin
			if (grant_idx == idx_bits'(num_entries - 1))
				priority_ptr <= '0;
			else
				priority_ptr <= grant_idx + 1'b1;
		end
	end
endmodule

//--- verif/l2_cache_tb.sv
// Testbench for the L2 cache, runs the directed tests and checks responses with assertions
`timescale 1ns/100ps
`include "l2_cache_settings.svh"

module l2_cache_tb
	import l2_cache_pkg::*;
();

	localparam set_bits = $bits(l2_set_idx_t);
	localparam cores = `L2_NUM_CORES;

	logic clk;
	logic reset;
	logic core_req_valid[cores];
	logic core_req_store[cores];
	l2_addr_t core_req_addr[cores];
	cache_line_t core_req_data[cores];
	logic l2_ready[cores];
	logic resp_valid;
	core_id_t resp_core;
	logic resp_store;
	l2_addr_t resp_addr;
	cache_line_t resp_data;
	logic mem_read_req;
	logic mem_write_req;
	l2_addr_t mem_addr;
	cache_line_t mem_write_data;
	logic mem_read_valid;
	cache_line_t mem_read_data;

	// Run bookkeeping
	string test_name = "reset";
	int cycle = 0;
	int requests_issued = 0;
	int reads_expected = 0;
	int reads_issued = 0;
	int data_errors = 0;
	int timing_errors = 0;
	int protocol_errors = 0;
	logic [31:0] lfsr_state = 32'h2c3b_7cb1;
	logic slow_mem = 1'b0;

	// Memory model and the reference contents that responses are predicted from
	cache_line_t mem_model[l2_addr_t];
	cache_line_t ref_mem[l2_addr_t];
	int read_timer = 0;
	cache_line_t read_line;

	// Which line the testbench believes lives in each set, and lines with a read in flight
	logic res_valid[`L2_NUM_SETS];
	l2_addr_t res_addr[`L2_NUM_SETS];
	logic pending_line[l2_addr_t];

	// Expected responses per core, and expected memory writes in order
	cache_line_t exp_data_q[cores][$];
	l2_addr_t exp_addr_q[cores][$];
	logic exp_store_q[cores][$];
	logic exp_fast_q[cores][$];
	int exp_cycle_q[cores][$];
	l2_addr_t wr_addr_q[$];
	cache_line_t wr_data_q[$];

	// Queue heads refreshed on every falling edge for the assertions
	logic head_valid[cores];
	cache_line_t head_data[cores];
	l2_addr_t head_addr[cores];
	logic head_store[cores];
	logic head_fast[cores];
	int head_cycle[cores];
	logic wq_valid;
	l2_addr_t wq_addr;
	cache_line_t wq_data;

	tb_clock_gen u_tb_clock_gen(.clk(clk), .reset(reset));

	l2_cache_top u_l2_cache_top(.*);

	// Galois LFSR, one step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;

		value = '0;
		for (int i = 0; i < n; i++)
		begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
		end
		return value;
	endfunction

	function automatic cache_line_t random_line();
		cache_line_t line;

		for (int i = 0; i < `L2_LINE_BITS / 32; i++)
			line[i * 32 +: 32] = rand_bits(32);
		return line;
	endfunction

	// Untouched memory holds the line address in every word, each word XORed with its position
	function automatic cache_line_t line_pattern(input l2_addr_t a);
		cache_line_t line;

		for (int i = 0; i < `L2_LINE_BITS / 32; i++)
			line[i * 32 +: 32] = 32'(a) ^ 32'(i);
		return line;
	endfunction

	// Sends one request from a core, starting on a falling edge and ending on one
	task automatic issue_request(input int c, input logic store, input l2_addr_t addr,
		input cache_line_t data);
		l2_set_idx_t set;
		logic fast;
		cache_line_t expect_line;

		requests_issued++;
		core_req_valid[c] = 1'b1;
		core_req_store[c] = store;
		core_req_addr[c] = addr;
		core_req_data[c] = data;
		#1;
		while (!l2_ready[c])
		begin
			@(negedge clk);
			#1;
		end
		// The request is taken at the coming rising edge
		set = addr[set_bits - 1:0];
		if (store)
		begin
			expect_line = data;
			ref_mem[addr] = data;
			fast = 1'b1;
			wr_addr_q.push_back(addr);
			wr_data_q.push_back(data);
		end
		else
		begin
			expect_line = ref_mem.exists(addr) ? ref_mem[addr] : line_pattern(addr);
			fast = res_valid[set] && res_addr[set] == addr;
			if (!fast && !pending_line.exists(addr))
			begin
				pending_line[addr] = 1'b1;
				reads_expected++;
			end
		end
		exp_data_q[c].push_back(expect_line);
		exp_addr_q[c].push_back(addr);
		exp_store_q[c].push_back(store);
		exp_fast_q[c].push_back(fast);
		exp_cycle_q[c].push_back(cycle);
		@(negedge clk);
		core_req_valid[c] = 1'b0;
	endtask

	task automatic store_burst(input int c, input int n, input int base);
		for (int i = 0; i < n; i++)
			issue_request(c, 1'b1, l2_addr_t'(base + c * 16 + i), random_line());
	endtask

	// Waits on falling edges until every response and memory write has been seen
	task automatic wait_idle();
		logic busy;

		busy = 1'b1;
		while (busy)
		begin
			@(negedge clk);
			busy = wr_addr_q.size() != 0;
			for (int c = 0; c < cores; c++)
				busy = busy || exp_data_q[c].size() != 0;
		end
	endtask

	// Memory port model; reads answer after 3 to 10 cycles
	always @(posedge clk)
	begin
		if (!reset && mem_write_req)
			mem_model[mem_addr] = mem_write_data;
		if (!reset && mem_read_req)
		begin
			reads_issued++;
			read_line = mem_model.exists(mem_addr) ? mem_model[mem_addr] : line_pattern(mem_addr);
			read_timer = slow_mem ? 10 : 3 + int'(rand_bits(3));
		end
	end

	always @(negedge clk)
	begin
		mem_read_valid = 1'b0;
		if (read_timer > 0)
		begin
			read_timer--;
			if (read_timer == 0)
			begin
				mem_read_valid = 1'b1;
				mem_read_data = read_line;
			end
		end
	end

	// Retire responses and writes; a load response leaves its line resident
	always @(posedge clk)
	begin
		if (!reset && resp_valid && exp_data_q[resp_core].size() != 0)
		begin
			void'(exp_data_q[resp_core].pop_front());
			void'(exp_addr_q[resp_core].pop_front());
			void'(exp_store_q[resp_core].pop_front());
			void'(exp_fast_q[resp_core].pop_front());
			void'(exp_cycle_q[resp_core].pop_front());
			if (!resp_store)
			begin
				res_valid[resp_addr[set_bits - 1:0]] = 1'b1;
				res_addr[resp_addr[set_bits - 1:0]] = resp_addr;
				pending_line.delete(resp_addr);
			end
		end
		if (!reset && mem_write_req && wr_addr_q.size() != 0)
		begin
			void'(wr_addr_q.pop_front());
			void'(wr_data_q.pop_front());
		end
	end

	always @(negedge clk)
	begin
		for (int c = 0; c < cores; c++)
		begin
			head_valid[c] = exp_data_q[c].size() != 0;
			head_data[c] = head_valid[c] ? exp_data_q[c][0] : '0;
			head_addr[c] = head_valid[c] ? exp_addr_q[c][0] : '0;
			head_store[c] = head_valid[c] ? exp_store_q[c][0] : 1'b0;
			head_fast[c] = head_valid[c] ? exp_fast_q[c][0] : 1'b0;
			head_cycle[c] = head_valid[c] ? exp_cycle_q[c][0] : 0;
		end
		wq_valid = wr_addr_q.size() != 0;
		wq_addr = wq_valid ? wr_addr_q[0] : '0;
		wq_data = wq_valid ? wr_data_q[0] : '0;
	end

	// Grant history for the round-robin check while every core is requesting
	logic all_req;
	logic any_ready;
	int acc_id;
	int hist[3];
	int hist_count;
	logic fair_ok;

	always @*
	begin
		all_req = 1'b1;
		any_ready = 1'b0;
		acc_id = 0;
		for (int c = 0; c < cores; c++)
		begin
			all_req = all_req && core_req_valid[c];
			if (l2_ready[c])
			begin
				any_ready = 1'b1;
				acc_id = c;
			end
		end
		fair_ok = 1'b1;
		for (int i = 0; i < 3; i++)
			if (i < hist_count && hist[i] == acc_id)
				fair_ok = 1'b0;
	end

	always @(posedge clk, posedge reset)
	begin
		if (reset)
			hist_count <= 0;
		else if (all_req && any_ready)
		begin
			hist[0] <= acc_id;
			hist[1] <= hist[0];
			hist[2] <= hist[1];
			hist_count <= hist_count < 3 ? hist_count + 1 : 3;
		end
		else if (!all_req)
			hist_count <= 0;
	end

	// Cycle count drives both the latency check and the timeout
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle > 40 * requests_issued + 200)
		begin
			$display("Timeout in test %s, the cache stopped answering", test_name);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	assert property (@(posedge clk) disable iff (reset) resp_valid |-> head_valid[resp_core])
	else
	begin
		protocol_errors++;
		$display("Test %s: response to core %0d that had nothing outstanding", test_name,
			$sampled(resp_core));
	end

	assert property (@(posedge clk) disable iff (reset)
		resp_valid && head_valid[resp_core] |-> resp_data == head_data[resp_core])
	else
	begin
		data_errors++;
		$display("[ERROR] %s: expected %h, actual %h", test_name,
			$sampled(head_data[resp_core]), $sampled(resp_data));
	end

	assert property (@(posedge clk) disable iff (reset)
		resp_valid && head_valid[resp_core] |-> resp_addr == head_addr[resp_core]
		&& resp_store == head_store[resp_core])
	else
	begin
		data_errors++;
		$display("[ERROR] %s: expected address %h store %b, actual %h store %b", test_name,
			$sampled(head_addr[resp_core]), $sampled(head_store[resp_core]),
			$sampled(resp_addr), $sampled(resp_store));
	end

	// Hits and stores answer three cycles after acceptance
	assert property (@(posedge clk) disable iff (reset)
		resp_valid && head_valid[resp_core] && head_fast[resp_core]
		|-> cycle == head_cycle[resp_core] + 3)
	else
	begin
		timing_errors++;
		$display("[ERROR] %s: expected response in cycle %0d, actual %0d", test_name,
			$sampled(head_cycle[resp_core]) + 3, $sampled(cycle));
	end

	assert property (@(posedge clk) disable iff (reset)
		mem_write_req |-> wq_valid && mem_addr == wq_addr && mem_write_data == wq_data)
	else
	begin
		data_errors++;
		$display("[ERROR] %s: expected write %h, actual %h", test_name,
			$sampled(wq_data), $sampled(mem_write_data));
	end

	assert property (@(posedge clk) disable iff (reset) mem_read_req |-> reads_issued < reads_expected)
	else
	begin
		protocol_errors++;
		$display("Test %s: memory read of line %h that should have hit", test_name,
			$sampled(mem_addr));
	end

	assert property (@(posedge clk) disable iff (reset)
		u_l2_cache_top.bi_stall || u_l2_cache_top.bi_restart |-> !any_ready)
	else
	begin
		protocol_errors++;
		$display("Test %s: a core saw ready during a stall or restart", test_name);
	end

	assert property (@(posedge clk) disable iff (reset) all_req && any_ready |-> fair_ok)
	else
	begin
		protocol_errors++;
		$display("Test %s: core %0d granted twice within four grants", test_name,
			$sampled(acc_id));
	end

	initial
	begin
		for (int c = 0; c < cores; c++)
		begin
			core_req_valid[c] = 1'b0;
			core_req_store[c] = 1'b0;
			core_req_addr[c] = '0;
			core_req_data[c] = '0;
		end
		for (int s = 0; s < `L2_NUM_SETS; s++)
			res_valid[s] = 1'b0;
		mem_read_valid = 1'b0;
		mem_read_data = '0;
		@(negedge reset);
		@(negedge clk);

		test_name = "load_miss";
		issue_request(0, 1'b0, 26'h10, '0);
		wait_idle();

		test_name = "load_hit";
		issue_request(2, 1'b0, 26'h10, '0);
		wait_idle();

		// Store hit on a resident line, then a store miss, each read back by another core
		test_name = "store";
		issue_request(1, 1'b1, 26'h10, random_line());
		wait_idle();
		issue_request(3, 1'b0, 26'h10, '0);
		wait_idle();
		issue_request(1, 1'b1, 26'h23, random_line());
		wait_idle();
		issue_request(0, 1'b0, 26'h23, '0);
		wait_idle();

		test_name = "round_robin";
		fork
			store_burst(0, 4, 'h100);
			store_burst(1, 4, 'h100);
			store_burst(2, 4, 'h100);
			store_burst(3, 4, 'h100);
		join
		wait_idle();

		// Both addresses map to set 5 and keep evicting each other
		test_name = "set_conflict";
		for (int i = 0; i < 4; i++)
		begin
			issue_request(0, 1'b0, i % 2 ? 26'h15 : 26'h05, '0);
			wait_idle();
		end

		test_name = "collided_miss";
		fork
			issue_request(0, 1'b0, 26'h37, '0);
			issue_request(1, 1'b0, 26'h37, '0);
		join
		wait_idle();

		// A slow read holds the queue head while stores pile up behind it
		// The bursts are long enough that cores are still requesting once the queue stalls
		test_name = "queue_stall";
		slow_mem = 1'b1;
		fork
			issue_request(0, 1'b0, 26'h48, '0);
			store_burst(1, 5, 'h200);
			store_burst(2, 5, 'h200);
			store_burst(3, 5, 'h200);
		join
		wait_idle();
		slow_mem = 1'b0;

		test_name = "final";
		assert (reads_issued == reads_expected)
		else
		begin
			protocol_errors++;
			$display("[ERROR] %s: expected %0d memory reads, actual %0d", test_name,
				reads_expected, reads_issued);
		end

		$display("Errors: data %0d, timing %0d, protocol %0d", data_errors, timing_errors,
			protocol_errors);
		if (data_errors + timing_errors + protocol_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end
endmodule

//--- verif/tb_clock_gen.sv
// Testbench clock and reset source, a 4 ns clock with reset held for the first three cycles
`timescale 1ns/100ps

module tb_clock_gen
(
	output logic clk,
	output logic reset
);

	// Half period of 2 ns gives the 4 ns clock
	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// Reset drops on a falling edge so it never races the rising edge
	initial
	begin
		reset = 1'b1;
		repeat (3)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end
endmodule
